//--- design/rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

////////////////////
// Datapath widths
////////////////////

// Data, address and instruction width
`define RV_XLEN 32

// Architectural integer registers
`define RV_NUM_REGS 32

// Major opcode field in insn[6:0]
`define RV_OPC_W 7

////////////////////
// Program counter
////////////////////

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// One 32-bit instruction per fetch
`define RV_PC_STEP 32'd4

// Integer computational opcodes
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP     7'b0110011

`endif

//--- design/rv_core_pkg.sv
`include "rv_core_params.svh"

package rv_core_pkg;

    ////////////////////
    // Datapath types
    ////////////////////

    // Data word, PC or raw instruction
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register index, 0 doubles as "no write" on a destination
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

    // {insn[30], funct3}
    typedef logic [3:0] funct_t;

    ////////////////////
    // ALU operations
    ////////////////////

    // Encoding kept from the older single-file core
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_SLT  = 4'b0010,  // Signed compare
        ALU_SLTU = 4'b0011,  // Unsigned compare
        ALU_SLL  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_XOR  = 4'b0110,
        ALU_OR   = 4'b0111,
        ALU_AND  = 4'b1000,
        ALU_SRA  = 4'b1001   // Arithmetic right shift
    } alu_op_t;

endpackage

//--- design/rv_fetch_stage.sv
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_fetch_stage import rv_core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall,      // Hazard hold from decode
    input  word_t imem_insn,  // Combinational instruction memory data
    output word_t imem_addr,
    output word_t if_pc,
    output word_t if_insn
);

    word_t pc;

    // Instruction memory sees the PC directly
    assign imem_addr = pc;

    ////////////////////
    // PC and IF/ID
    ////////////////////

    // Instruction word is control state, opcode 0 decodes as a no-op
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= `RV_RESET_PC;
            if_insn <= '0;
        end else if (!stall) begin
            pc      <= pc + `RV_PC_STEP;  // Sequential fetch only
            if_insn <= imem_insn;
        end
        // Stall holds both PC and fetched word
    end

    // PC copy travels with the instruction
    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc <= pc;
        end
    end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_regfile import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,      // Read port A index
    input  reg_idx_t rs2,      // Read port B index
    input  reg_idx_t wr_rd,    // Write index, 0 means no write
    input  word_t    wr_data,
    output word_t    rs1_val,
    output word_t    rs2_val
);

    word_t regs [`RV_NUM_REGS];

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;  // Whole file cleared
            end
        end else if (wr_rd != '0) begin
            regs[wr_rd] <= wr_data;
        end
    end

    ////////////////////
    // Read ports
    ////////////////////

    // x0 hard-wired to zero
    // Same-cycle write wins over the stored value
    always_comb begin
        if (rs1 == '0) begin
            rs1_val = '0;
        end else if (rs1 == wr_rd) begin
            rs1_val = wr_data;  // Write-first bypass
        end else begin
            rs1_val = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rs2_val = '0;
        end else if (rs2 == wr_rd) begin
            rs2_val = wr_data;  // Write-first bypass
        end else begin
            rs2_val = regs[rs2];
        end
    end

endmodule

//--- design/rv_decode_stage.sv
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_decode_stage import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    if_pc,
    input  word_t    if_insn,
    input  reg_idx_t ex_rd,         // EX/MEM destination
    input  reg_idx_t wb_rd,         // MEM/WB destination, register write
    input  word_t    wb_data,
    output logic     stall,
    output word_t    id_pc,
    output word_t    id_rs1_val,
    output word_t    id_rs2_val,
    output word_t    id_imm,
    output logic     id_use_imm,    // OP-IMM, operand B from immediate
    output logic     id_is_reg_op,  // OP, full funct decode
    output funct_t   id_funct,
    output reg_idx_t id_rd
);

    logic [`RV_OPC_W-1:0] opcode;
    logic                 is_op;
    logic                 is_op_imm;
    reg_idx_t             rs1;
    reg_idx_t             rs2;
    reg_idx_t             dec_rd;
    word_t                dec_imm;
    word_t                rs1_val;
    word_t                rs2_val;
    logic                 hit_ex;
    logic                 hit_mem;

    ////////////////////
    // Field decode
    ////////////////////

    assign opcode    = if_insn[6:0];
    assign is_op     = (opcode == `RV_OPC_OP);
    assign is_op_imm = (opcode == `RV_OPC_OP_IMM);

    assign rs1 = if_insn[19:15];
    assign rs2 = if_insn[24:20];  // Also imm[4:0] on OP-IMM

    // Anything that is not OP or OP-IMM never writes
    assign dec_rd = (is_op || is_op_imm) ? if_insn[11:7] : '0;

    // I-type immediate, sign-extended
    assign dec_imm = {{(`RV_XLEN-12){if_insn[31]}}, if_insn[31:20]};

    // Write port driven from MEM/WB
    rv_regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .wr_rd   (wb_rd),
        .wr_data (wb_data),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    ////////////////////
    // Interlock
    ////////////////////

    // Producer in EX or in the memory slot blocks decode
    // Both source fields are compared for every opcode
    assign hit_ex  = (id_rd != '0) && ((id_rd == rs1) || (id_rd == rs2));
    assign hit_mem = (ex_rd != '0) && ((ex_rd == rs1) || (ex_rd == rs2));
    assign stall   = hit_ex || hit_mem;

    ////////////////////
    // ID/EX register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_rd        <= '0;
            id_use_imm   <= 1'b0;
            id_is_reg_op <= 1'b0;
        end else if (stall) begin
            id_rd        <= '0;  // Bubble
            id_use_imm   <= 1'b0;
            id_is_reg_op <= 1'b0;
        end else begin
            id_rd        <= dec_rd;
            id_use_imm   <= is_op_imm;
            id_is_reg_op <= is_op;
        end
    end

    // Payload follows decode every cycle, a bubble carries rd 0 anyway
    always_ff @(posedge clk) begin
        id_pc      <= if_pc;
        id_rs1_val <= rs1_val;
        id_rs2_val <= rs2_val;
        id_imm     <= dec_imm;
        id_funct   <= {if_insn[30], if_insn[14:12]};  // funct7[5], funct3
    end

endmodule

//--- design/rv_execute_stage.sv
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_execute_stage import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    id_rs1_val,
    input  word_t    id_rs2_val,
    input  word_t    id_imm,
    input  logic     id_use_imm,    // Operand B from immediate
    input  logic     id_is_reg_op,  // OP rather than OP-IMM
    input  funct_t   id_funct,
    input  reg_idx_t id_rd,
    output reg_idx_t ex_rd,         // EX/MEM destination, to interlock
    output reg_idx_t wb_rd,         // MEM/WB destination
    output word_t    wb_data
);

    alu_op_t                     alu_op;
    word_t                       op_b;
    logic [$clog2(`RV_XLEN)-1:0] shamt;
    word_t                       alu_res;
    word_t                       ex_result;  // EX/MEM result

    ////////////////////
    // ALU control
    ////////////////////

    always_comb begin
        alu_op = ALU_ADD;  // Unmapped codes fall back to add
        if (id_is_reg_op) begin
            // OP uses bit 30 for sub and sra
            case (id_funct)
                4'b0000: alu_op = ALU_ADD;
                4'b1000: alu_op = ALU_SUB;
                4'b0001: alu_op = ALU_SLL;
                4'b0010: alu_op = ALU_SLT;
                4'b0011: alu_op = ALU_SLTU;
                4'b0100: alu_op = ALU_XOR;
                4'b0101: alu_op = ALU_SRL;
                4'b1101: alu_op = ALU_SRA;
                4'b0110: alu_op = ALU_OR;
                4'b0111: alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end else begin
            // Bit 30 here is an immediate bit, only srai looks at it
            case (id_funct[2:0])
                3'b000:  alu_op = ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = id_funct[3] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    ////////////////////
    // ALU
    ////////////////////

    assign op_b  = id_use_imm ? id_imm : id_rs2_val;
    assign shamt = op_b[4:0];  // Low five bits only

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = id_rs1_val + op_b;
            ALU_SUB:  alu_res = id_rs1_val - op_b;
            ALU_SLT:  alu_res = word_t'($signed(id_rs1_val) < $signed(op_b));
            ALU_SLTU: alu_res = word_t'(id_rs1_val < op_b);  // 0 or 1
            ALU_XOR:  alu_res = id_rs1_val ^ op_b;
            ALU_OR:   alu_res = id_rs1_val | op_b;
            ALU_AND:  alu_res = id_rs1_val & op_b;
            ALU_SLL:  alu_res = id_rs1_val << shamt;
            ALU_SRL:  alu_res = id_rs1_val >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(id_rs1_val) >>> shamt);  // Sign fill
            default:  alu_res = id_rs1_val + op_b;
        endcase
    end

    ////////////////////
    // EX/MEM and MEM/WB
    ////////////////////

    // Destinations carry the write intent, so they reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_rd <= '0;
            wb_rd <= '0;
        end else begin
            ex_rd <= id_rd;
            wb_rd <= ex_rd;  // Memory slot only delays
        end
    end

    always_ff @(posedge clk) begin
        ex_result <= alu_res;
        wb_data   <= ex_result;
    end

endmodule

//--- design/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    imem_insn,     // Word at imem_addr, same cycle
    output word_t    imem_addr,
    output logic     retire_valid,  // One register write this cycle
    output reg_idx_t retire_rd,
    output word_t    retire_data
);

    // Fetch to decode
    logic     stall;
    word_t    if_pc;
    word_t    if_insn;

    // Decode to execute
    word_t    id_rs1_val;
    word_t    id_rs2_val;
    word_t    id_imm;
    logic     id_use_imm;
    logic     id_is_reg_op;
    funct_t   id_funct;
    reg_idx_t id_rd;

    // Execute back to decode
    reg_idx_t ex_rd;
    reg_idx_t wb_rd;
    word_t    wb_data;

    ////////////////////
    // Stages
    ////////////////////

    rv_fetch_stage fetch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .imem_insn (imem_insn),
        .imem_addr (imem_addr),
        .if_pc     (if_pc),
        .if_insn   (if_insn)
    );

    // No branches, so the ID/EX PC has no consumer
    rv_decode_stage decode_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_pc        (if_pc),
        .if_insn      (if_insn),
        .ex_rd        (ex_rd),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .stall        (stall),
        .id_pc        (),
        .id_rs1_val   (id_rs1_val),
        .id_rs2_val   (id_rs2_val),
        .id_imm       (id_imm),
        .id_use_imm   (id_use_imm),
        .id_is_reg_op (id_is_reg_op),
        .id_funct     (id_funct),
        .id_rd        (id_rd)
    );

    rv_execute_stage execute_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_rs1_val   (id_rs1_val),
        .id_rs2_val   (id_rs2_val),
        .id_imm       (id_imm),
        .id_use_imm   (id_use_imm),
        .id_is_reg_op (id_is_reg_op),
        .id_funct     (id_funct),
        .id_rd        (id_rd),
        .ex_rd        (ex_rd),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    // Retire mirrors the register-file write port
    assign retire_valid = (wb_rd != '0);
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

//--- verification/rv_core_props.sv
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_core_props import rv_core_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input word_t    imem_addr,
    input logic     retire_valid,
    input reg_idx_t retire_rd,
    input word_t    retire_data
);

    ////////////////////
    // Fetch address
    ////////////////////

    // Reset parks the PC once the async clear has landed
    a_reset_pc: assert property (@(posedge clk)
        !rst_n ##1 !rst_n |-> imem_addr == `RV_RESET_PC)
        else $error("imem_addr is not the reset PC while reset is asserted");

    // Hold on stall, otherwise one step
    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (imem_addr == $past(imem_addr))
                      || (imem_addr == $past(imem_addr) + `RV_PC_STEP))
        else $error("imem_addr neither held nor advanced by one step");

    ////////////////////
    // Retire port
    ////////////////////

    a_no_retire_in_reset: assert property (@(posedge clk)
        !rst_n ##1 !rst_n |-> !retire_valid)
        else $error("retire_valid is high during reset");

    // Every retired write carries a known destination and value
    a_retire_known: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> !$isunknown({retire_rd, retire_data}))
        else $error("retire_valid is high with an unknown destination or value");

endmodule

// Attached to every core instance
bind rv_core_top rv_core_props props_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_addr    (imem_addr),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
);

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_core_tb import rv_core_pkg::*; ();

    localparam int PROG_WORDS   = 64;
    localparam int DONE_TIMEOUT = 2000;  // Cycles, worst case is 3 per insn
    localparam int DRAIN_CYCLES = 20;    // Watch for stray retires

    logic     clk;
    logic     rst_n;
    word_t    imem_insn;
    word_t    imem_addr;
    logic     retire_valid;
    reg_idx_t retire_rd;
    word_t    retire_data;

    word_t    prog [PROG_WORDS];
    word_t    model_regs [`RV_NUM_REGS];
    reg_idx_t exp_rd_q [$];   // Expected retires, program order
    word_t    exp_data_q [$];
    integer   seed;
    int       errors;
    int       retired;
    int       expected_total;

    rv_core_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_insn    (imem_insn),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    ////////////////////
    // Program memory
    ////////////////////

    // Past the program end, a no-op word built from the full address
    function automatic word_t fetch_word(input word_t addr);
        if ((addr >> 2) < PROG_WORDS) begin
            return prog[addr >> 2];
        end
        return {addr[31:7] ^ {18'h0, addr[6:0]}, 7'b000_0000};
    endfunction

    // Registered drive of the next fetch address, decode stall holds it
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_insn <= fetch_word(`RV_RESET_PC);
        end else if (dut_i.stall) begin
            imem_insn <= fetch_word(imem_addr);
        end else begin
            imem_insn <= fetch_word(imem_addr + `RV_PC_STEP);
        end
    end

    task automatic build_program();
        word_t r;
        word_t w;
        for (int i = 0; i < PROG_WORDS; i++) begin
            r = $random(seed);
            w = $random(seed);
            if (r[31:29] == 3'b000) begin
                // Other opcode, bit 2 flip moves OP/OP-IMM to U-type
                if (w[6:0] == `RV_OPC_OP || w[6:0] == `RV_OPC_OP_IMM) begin
                    w[2] = 1'b1;
                end
                prog[i] = w;
            end else if (r[17]) begin
                // OP, registers x0..x7 for dense hazards
                prog[i] = {1'b0, r[16], 5'b0, 2'b00, r[12:10], 2'b00, r[9:7],
                           r[15:13], 2'b00, r[6:4], `RV_OPC_OP};
            end else begin
                prog[i] = {w[11:0], 2'b00, r[9:7], r[15:13], 2'b00, r[6:4],
                           `RV_OPC_OP_IMM};  // OP-IMM
            end
        end
    endtask

    ////////////////////
    // ISA model
    ////////////////////

    task automatic run_model();
        word_t    insn;
        word_t    a;
        word_t    b;
        word_t    res;
        reg_idx_t rd;
        logic     is_op;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            insn  = prog[i];
            rd    = insn[11:7];
            is_op = (insn[6:0] == `RV_OPC_OP);
            if (insn[6:0] != `RV_OPC_OP && insn[6:0] != `RV_OPC_OP_IMM) begin
                continue;  // No-op, nothing retires
            end
            a = model_regs[insn[19:15]];
            b = is_op ? model_regs[insn[24:20]] : {{20{insn[31]}}, insn[31:20]};
            case (insn[14:12])
                3'b000:  res = (is_op && insn[30]) ? a - b : a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011:  res = (a < b) ? 32'd1 : 32'd0;
                3'b100:  res = a ^ b;
                3'b101:  res = insn[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
            // OP with bit 30 on any other funct3 is not a valid code, adds
            if (is_op && insn[30] && insn[14:12] != 3'b000 && insn[14:12] != 3'b101) begin
                res = a + b;
            end
            if (rd != '0) begin
                model_regs[rd] = res;
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(res);
            end
        end
    endtask

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Retire monitor, sampled mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && retire_valid) begin
                if (exp_rd_q.size() == 0) begin
                    errors++;
                    $display("Retire of x%0d seen with no expected retire left", retire_rd);
                end else begin
                    check_value("retire_rd", word_t'(retire_rd), word_t'(exp_rd_q.pop_front()));
                    check_value("retire_data", retire_data, exp_data_q.pop_front());
                    retired++;
                end
            end
        end
    end

    initial begin
        int cycles;
        errors    = 0;
        retired   = 0;
        seed      = 32'hda62_e727;
        rst_n     = 1'b0;
        imem_insn = '0;
        build_program();
        run_model();
        expected_total = exp_rd_q.size();

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("imem_addr", imem_addr, `RV_RESET_PC);
        check_value("retire_valid", word_t'(retire_valid), '0);

        // Wait for every expected retire
        cycles = 0;
        while (retired < expected_total && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (retired < expected_total) begin
            errors++;
            $display("Timeout: only %0d of %0d expected retires seen", retired, expected_total);
        end

        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("Errors: %0d, retires seen: %0d of %0d", errors, retired, expected_total);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+design
design/rv_core_pkg.sv
design/rv_fetch_stage.sv
design/rv_regfile.sv
design/rv_decode_stage.sv
design/rv_execute_stage.sv
design/rv_core_top.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv
